//--- source/freq_counter_params.svh
/*
 * Frequency counter widths and default constants
 * shared by the package and every pipeline stage
 */

`ifndef FREQ_COUNTER_PARAMS_SVH
`define FREQ_COUNTER_PARAMS_SVH

// edge tally width, enough for a full gate at the top input rate
`define FC_COUNT_BITS 28

// reference frequency constant in 100 Hz units
`define FC_REF_BITS 24

// scaled reading, holds 99999999
`define FC_READING_BITS 27

// seven-segment digits on the readout
`define FC_DIGITS 8

// flops in each input synchronizer
`define FC_SYNC_STAGES 2

// largest value that fits on eight digits
`define FC_READING_MAX 99999999

// gate length as a power of two of reference edges
`define FC_GATE_LOG2_DEFAULT 20

// clocks per displayed digit as a power of two
`define FC_SCAN_LOG2_DEFAULT 12

// 100 MHz reference expressed in 100 Hz units
`define FC_REF_FREQ_100HZ_DEFAULT 1000000

`endif

//--- source/freq_counter_pkg.sv
/*
 * Frequency counter types
 * vector widths, stage payload structs and FSM encodings
 */

`default_nettype none

`include "freq_counter_params.svh"

package freq_counter_pkg;

	// edges of the measured signal seen in one gate
	typedef logic [`FC_COUNT_BITS-1:0] edge_count_t;

	// frequency in units of 100 Hz
	typedef logic [`FC_READING_BITS-1:0] reading_t;

	// packed decimal, digit 0 in the low nibble
	typedef logic [4*`FC_DIGITS-1:0] bcd_t;

	// segments, bit 0 is a and bit 6 is g, active low
	typedef logic [6:0] seg_t;

	// one-hot digit enable, active high
	typedef logic [`FC_DIGITS-1:0] anode_t;

	// tally offered by the edge counter
	typedef struct packed {
		edge_count_t count;
		logic overflow;
	} tally_s;

	// scaled reading offered to the converter
	typedef struct packed {
		reading_t value;
		logic saturated;
	} reading_s;

	// shift-add multiplier states
	typedef enum logic [1:0] {
		SCALER_IDLE,
		SCALER_MULTIPLY,
		SCALER_DONE
	} scaler_state_e;

	// double dabble states
	typedef enum logic [1:0] {
		BCD_IDLE,
		BCD_SHIFT,
		BCD_DONE
	} bcd_state_e;

endpackage

`default_nettype wire

//--- source/gate_timer.sv
/*
 * Gate timer
 * synchronizes the reference and toggles the gate every 2^GATE_LOG2 edges
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module gate_timer #(
	parameter int GATE_LOG2 = `FC_GATE_LOG2_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic ref_in,
	output logic gate
);

	// synchronizer chain plus one flop for the edge detector
	logic [`FC_SYNC_STAGES:0] ref_sync;
	logic ref_rise;
	// reference edges within the current gate phase
	logic [GATE_LOG2-1:0] ref_count;

	// rising edge once the level has crossed the synchronizer
	assign ref_rise = ref_sync[`FC_SYNC_STAGES-1] & ~ref_sync[`FC_SYNC_STAGES];

	always_ff @(posedge clock) begin
		if (reset) begin
			ref_sync <= '0;
			ref_count <= '0;
			gate <= 1'b0;
		end else begin
			// shift in the asynchronous reference
			ref_sync <= {ref_sync[`FC_SYNC_STAGES-1:0], ref_in};
			if (ref_rise) begin
				ref_count <= ref_count + 1'b1;
				// counter wraps, phase ends
				if (&ref_count) begin
					gate <= ~gate;
				end
			end
		end
	end

	// the gate moves only on a reference edge
	gate_on_ref_edge: assert property (
		@(posedge clock) disable iff (reset)
		$changed(gate) |-> $past(ref_rise)
	) else $error("gate toggled without a reference edge");

endmodule

`default_nettype wire

//--- source/edge_tally.sv
/*
 * Edge tally
 * counts measured-signal edges while the gate is open and offers the count
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module edge_tally (
	input logic clock,
	input logic reset,
	input logic meas_in,
	input logic gate,
	output logic tally_valid,
	output freq_counter_pkg::tally_s tally,
	input logic tally_ready
);

	logic [`FC_SYNC_STAGES:0] meas_sync;
	logic meas_rise;
	// gate level one cycle back
	logic gate_prev;
	logic gate_fall;
	// running count for the open gate
	freq_counter_pkg::edge_count_t count;
	logic overflow;
	// slot is free or frees up on this clock
	logic slot_free;

	assign meas_rise = meas_sync[`FC_SYNC_STAGES-1] & ~meas_sync[`FC_SYNC_STAGES];
	assign gate_fall = gate_prev & ~gate;
	assign slot_free = ~tally_valid | tally_ready;

	always_ff @(posedge clock) begin
		if (reset) begin
			meas_sync <= '0;
			gate_prev <= 1'b0;
			count <= '0;
			overflow <= 1'b0;
			tally_valid <= 1'b0;
		end else begin
			meas_sync <= {meas_sync[`FC_SYNC_STAGES-1:0], meas_in};
			gate_prev <= gate;
			// consumer took the tally
			if (tally_valid && tally_ready) begin
				tally_valid <= 1'b0;
			end
			if (gate_fall) begin
				// offer the finished count unless the old one still waits
				if (slot_free) begin
					tally_valid <= 1'b1;
				end
				count <= '0;
				overflow <= 1'b0;
			end else if (gate && meas_rise) begin
				count <= count + 1'b1;
				// wrap marks the count as unusable
				if (&count) begin
					overflow <= 1'b1;
				end
			end
		end
	end

	// payload copy, held while the tally waits
	always_ff @(posedge clock) begin
		if (gate_fall && slot_free) begin
			tally.count <= count;
			tally.overflow <= overflow;
		end
	end

	// payload holds until the handshake completes
	tally_stable: assert property (
		@(posedge clock) disable iff (reset)
		(tally_valid && !tally_ready) |=> (tally_valid && $stable(tally))
	) else $error("tally changed while waiting for ready");

endmodule

`default_nettype wire

//--- source/rate_scaler.sv
/*
 * Rate scaler
 * shift-add multiply of the tally by the reference, then shift and clamp
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module rate_scaler #(
	parameter int unsigned REF_FREQ_100HZ = `FC_REF_FREQ_100HZ_DEFAULT,
	parameter int GATE_LOG2 = `FC_GATE_LOG2_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic tally_valid,
	input freq_counter_pkg::tally_s tally,
	output logic tally_ready,
	output logic reading_valid,
	output freq_counter_pkg::reading_s reading,
	input logic reading_ready
);

	localparam int PROD_BITS = `FC_COUNT_BITS + `FC_REF_BITS;
	localparam int STEP_BITS = $clog2(`FC_REF_BITS);
	localparam logic [`FC_REF_BITS-1:0] REF_VALUE = REF_FREQ_100HZ[`FC_REF_BITS-1:0];
	localparam logic [PROD_BITS-1:0] PROD_MAX = PROD_BITS'(`FC_READING_MAX);

	freq_counter_pkg::scaler_state_e state;
	// multiplicand moves left as the multiplier moves right
	logic [PROD_BITS-1:0] multiplicand;
	logic [`FC_REF_BITS-1:0] multiplier;
	logic [PROD_BITS-1:0] product;
	logic [PROD_BITS-1:0] product_next;
	logic [PROD_BITS-1:0] scaled;
	logic [STEP_BITS-1:0] step;
	logic overflowed;
	logic clamp;

	assign product_next = multiplier[0] ? product + multiplicand : product;
	// divide by the gate length
	assign scaled = product >> GATE_LOG2;
	assign clamp = overflowed | (scaled > PROD_MAX);
	assign tally_ready = (state == freq_counter_pkg::SCALER_IDLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= freq_counter_pkg::SCALER_IDLE;
			step <= '0;
			reading_valid <= 1'b0;
		end else begin
			case (state)
				freq_counter_pkg::SCALER_IDLE: begin
					step <= '0;
					if (tally_valid) begin
						state <= freq_counter_pkg::SCALER_MULTIPLY;
					end
				end
				freq_counter_pkg::SCALER_MULTIPLY: begin
					step <= step + 1'b1;
					// one reference bit per clock
					if (step == STEP_BITS'(`FC_REF_BITS - 1)) begin
						state <= freq_counter_pkg::SCALER_DONE;
					end
				end
				freq_counter_pkg::SCALER_DONE: begin
					if (!reading_valid) begin
						reading_valid <= 1'b1;
					end else if (reading_ready) begin
						reading_valid <= 1'b0;
						state <= freq_counter_pkg::SCALER_IDLE;
					end
				end
				default: begin
					state <= freq_counter_pkg::SCALER_IDLE;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (tally_ready && tally_valid) begin
			multiplicand <= PROD_BITS'(tally.count);
			multiplier <= REF_VALUE;
			product <= '0;
			overflowed <= tally.overflow;
		end
		if (state == freq_counter_pkg::SCALER_MULTIPLY) begin
			product <= product_next;
			multiplicand <= multiplicand << 1;
			multiplier <= multiplier >> 1;
		end
		// result registered once, held until taken
		if (state == freq_counter_pkg::SCALER_DONE && !reading_valid) begin
			reading.value <= clamp ? freq_counter_pkg::reading_t'(`FC_READING_MAX) :
				scaled[`FC_READING_BITS-1:0];
			reading.saturated <= clamp;
		end
	end

	reading_in_range: assert property (
		@(posedge clock) disable iff (reset)
		reading_valid |-> (reading.value <= `FC_READING_MAX)
	) else $error("reading above the display limit");

endmodule

`default_nettype wire

//--- source/bcd_converter.sv
/*
 * BCD converter
 * iterative double dabble from the binary reading to eight decimal digits
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module bcd_converter (
	input logic clock,
	input logic reset,
	input logic reading_valid,
	input freq_counter_pkg::reading_s reading,
	output logic reading_ready,
	output logic bcd_valid,
	output freq_counter_pkg::bcd_t bcd
);

	localparam int STEP_BITS = $clog2(`FC_READING_BITS);

	freq_counter_pkg::bcd_state_e state;
	// binary bits still to shift in, msb first
	freq_counter_pkg::reading_t binary;
	// digits being built
	freq_counter_pkg::bcd_t work;
	freq_counter_pkg::bcd_t corrected;
	logic [STEP_BITS-1:0] step;

	// add 3 to any nibble of 5 or more before the shift
	function automatic freq_counter_pkg::bcd_t add_three(input freq_counter_pkg::bcd_t value);
		freq_counter_pkg::bcd_t result;
		result = value;
		for (int i = 0; i < `FC_DIGITS; i++) begin
			if (value[4*i +: 4] > 4'd4) begin
				result[4*i +: 4] = value[4*i +: 4] + 4'd3;
			end
		end
		return result;
	endfunction

	// every nibble a decimal digit
	function automatic logic digits_valid(input freq_counter_pkg::bcd_t value);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `FC_DIGITS; i++) begin
			if (value[4*i +: 4] > 4'd9) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	assign corrected = add_three(work);
	assign reading_ready = (state == freq_counter_pkg::BCD_IDLE);

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= freq_counter_pkg::BCD_IDLE;
			step <= '0;
			bcd_valid <= 1'b0;
		end else begin
			// single-cycle pulse
			bcd_valid <= 1'b0;
			case (state)
				freq_counter_pkg::BCD_IDLE: begin
					step <= '0;
					if (reading_valid) begin
						state <= freq_counter_pkg::BCD_SHIFT;
					end
				end
				freq_counter_pkg::BCD_SHIFT: begin
					step <= step + 1'b1;
					if (step == STEP_BITS'(`FC_READING_BITS - 1)) begin
						state <= freq_counter_pkg::BCD_DONE;
					end
				end
				freq_counter_pkg::BCD_DONE: begin
					bcd_valid <= 1'b1;
					state <= freq_counter_pkg::BCD_IDLE;
				end
				default: begin
					state <= freq_counter_pkg::BCD_IDLE;
				end
			endcase
		end
	end

	// datapath
	always_ff @(posedge clock) begin
		if (reading_ready && reading_valid) begin
			// saturated reading shows all nines
			binary <= reading.saturated ? freq_counter_pkg::reading_t'(`FC_READING_MAX) :
				reading.value;
			work <= '0;
		end
		if (state == freq_counter_pkg::BCD_SHIFT) begin
			work <= {corrected[4*`FC_DIGITS-2:0], binary[`FC_READING_BITS-1]};
			binary <= binary << 1;
		end
		if (state == freq_counter_pkg::BCD_DONE) begin
			bcd <= work;
		end
	end

	bcd_digits_decimal: assert property (
		@(posedge clock) disable iff (reset)
		bcd_valid |-> digits_valid(bcd)
	) else $error("bcd nibble above 9");

endmodule

`default_nettype wire

//--- source/digit_scanner.sv
/*
 * Digit scanner
 * holds the last BCD reading and multiplexes it onto a common-anode display
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module digit_scanner #(
	parameter int SCAN_LOG2 = `FC_SCAN_LOG2_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic bcd_valid,
	input freq_counter_pkg::bcd_t bcd,
	output freq_counter_pkg::seg_t segment,
	output freq_counter_pkg::anode_t anode
);

	localparam int INDEX_BITS = $clog2(`FC_DIGITS);

	// reading on show
	freq_counter_pkg::bcd_t held;
	// clocks spent on the current digit
	logic [SCAN_LOG2-1:0] prescale;
	logic [INDEX_BITS-1:0] digit_index;
	logic [3:0] digit;

	assign digit = held[4*digit_index +: 4];

	always_ff @(posedge clock) begin
		if (reset) begin
			held <= '0;
			prescale <= '0;
			digit_index <= '0;
			anode <= freq_counter_pkg::anode_t'(1);
		end else begin
			if (bcd_valid) begin
				held <= bcd;
			end
			prescale <= prescale + 1'b1;
			// next digit when the prescaler wraps
			if (&prescale) begin
				anode <= {anode[`FC_DIGITS-2:0], anode[`FC_DIGITS-1]};
				if (digit_index == INDEX_BITS'(`FC_DIGITS - 1)) begin
					digit_index <= '0;
				end else begin
					digit_index <= digit_index + 1'b1;
				end
			end
		end
	end

	// segments g..a, low lights the segment
	always_comb begin
		case (digit)
			4'd0: segment = 7'b1000000;
			4'd1: segment = 7'b1111001;
			4'd2: segment = 7'b0100100;
			4'd3: segment = 7'b0110000;
			4'd4: segment = 7'b0011001;
			4'd5: segment = 7'b0010010;
			4'd6: segment = 7'b0000010;
			4'd7: segment = 7'b1111000;
			4'd8: segment = 7'b0000000;
			4'd9: segment = 7'b0010000;
			// blank for anything not decimal
			default: segment = 7'b1111111;
		endcase
	end

	anode_one_hot: assert property (
		@(posedge clock) disable iff (reset)
		$onehot(anode)
	) else $error("anode not one-hot");

	// rotating anode and digit index stay in step
	anode_matches_index: assert property (
		@(posedge clock) disable iff (reset)
		anode[digit_index]
	) else $error("anode and digit index disagree");

endmodule

`default_nettype wire

//--- source/freq_counter_top.sv
/*
 * Gated frequency counter
 * gate timer, edge tally, rate scaler, BCD converter and digit scanner
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module freq_counter_top #(
	parameter int unsigned REF_FREQ_100HZ = `FC_REF_FREQ_100HZ_DEFAULT,
	parameter int GATE_LOG2 = `FC_GATE_LOG2_DEFAULT,
	parameter int SCAN_LOG2 = `FC_SCAN_LOG2_DEFAULT
) (
	input logic clock,
	input logic reset,
	input logic ref_in,
	input logic meas_in,
	output logic gate,
	output logic bcd_valid,
	output freq_counter_pkg::bcd_t bcd,
	output freq_counter_pkg::seg_t segment,
	output freq_counter_pkg::anode_t anode
);

	// edge tally to rate scaler
	logic tally_valid;
	logic tally_ready;
	freq_counter_pkg::tally_s tally;
	// rate scaler to bcd converter
	logic reading_valid;
	logic reading_ready;
	freq_counter_pkg::reading_s reading;

	gate_timer #(
		.GATE_LOG2(GATE_LOG2)
	) i_gate_timer (
		.clock(clock),
		.reset(reset),
		.ref_in(ref_in),
		.gate(gate)
	);

	edge_tally i_edge_tally (
		.clock(clock),
		.reset(reset),
		.meas_in(meas_in),
		.gate(gate),
		.tally_valid(tally_valid),
		.tally(tally),
		.tally_ready(tally_ready)
	);

	rate_scaler #(
		.REF_FREQ_100HZ(REF_FREQ_100HZ),
		.GATE_LOG2(GATE_LOG2)
	) i_rate_scaler (
		.clock(clock),
		.reset(reset),
		.tally_valid(tally_valid),
		.tally(tally),
		.tally_ready(tally_ready),
		.reading_valid(reading_valid),
		.reading(reading),
		.reading_ready(reading_ready)
	);

	bcd_converter i_bcd_converter (
		.clock(clock),
		.reset(reset),
		.reading_valid(reading_valid),
		.reading(reading),
		.reading_ready(reading_ready),
		.bcd_valid(bcd_valid),
		.bcd(bcd)
	);

	digit_scanner #(
		.SCAN_LOG2(SCAN_LOG2)
	) i_digit_scanner (
		.clock(clock),
		.reset(reset),
		.bcd_valid(bcd_valid),
		.bcd(bcd),
		.segment(segment),
		.anode(anode)
	);

endmodule

`default_nettype wire

//--- tb/freq_counter_tb.sv
/*
 * Frequency counter testbench
 * drives reference and measured square waves, checks gate, BCD readings and display scan
 */

`timescale 1ns/10ps
`default_nettype none

`include "freq_counter_params.svh"

module freq_counter_tb;

	localparam int GATE_LOG2 = 4;
	localparam int unsigned REF_FREQ_100HZ = 16000000;
	localparam int SCAN_LOG2 = 2;
	// reference half period in clocks, long enough that the fast phase passes 100 edges
	localparam int REF_HALF = 20;
	localparam int GATE_EDGES = 1 << GATE_LOG2;
	// one open plus one closed phase
	localparam int GATE_PERIOD = 4 * GATE_EDGES * REF_HALF;
	localparam int FAST_CLOCKS = 3 * GATE_PERIOD;
	localparam int READINGS_WANTED = 6;
	localparam int TIMEOUT_CYCLES = 12 * GATE_PERIOD + 500;
	localparam longint READING_LIMIT = `FC_READING_MAX;

	logic clock = 1'b0;
	logic reset;
	logic ref_in;
	logic meas_in;
	logic gate;
	logic bcd_valid;
	freq_counter_pkg::bcd_t bcd;
	freq_counter_pkg::seg_t segment;
	freq_counter_pkg::anode_t anode;

	// model state
	logic [`FC_SYNC_STAGES:0] ref_pipe;
	logic [`FC_SYNC_STAGES:0] meas_pipe;
	logic gate_seen;
	int ref_edges;
	int meas_count;
	int tally_queue[$];
	int readings_taken = 0;
	int saturated_readings = 0;
	int plain_readings = 0;
	// display reference
	freq_counter_pkg::bcd_t shown_bcd;
	freq_counter_pkg::anode_t anode_seen;
	int cycles = 0;
	int seed = 32'hda4d;

	freq_counter_top #(
		.REF_FREQ_100HZ(REF_FREQ_100HZ),
		.GATE_LOG2(GATE_LOG2),
		.SCAN_LOG2(SCAN_LOG2)
	) i_dut (
		.clock(clock),
		.reset(reset),
		.ref_in(ref_in),
		.meas_in(meas_in),
		.gate(gate),
		.bcd_valid(bcd_valid),
		.bcd(bcd),
		.segment(segment),
		.anode(anode)
	);

	always #4 clock = ~clock;

	task automatic stop_with_failure();
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic report_failure(input string reason);
		$display("%s", reason);
		stop_with_failure();
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		$display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, expected);
		stop_with_failure();
	endtask

	// decimal digits of a binary value, digit 0 in the low nibble
	function automatic freq_counter_pkg::bcd_t to_bcd(input longint value);
		freq_counter_pkg::bcd_t digits;
		longint rest;
		digits = '0;
		rest = value;
		for (int i = 0; i < `FC_DIGITS; i++) begin
			digits[4*i +: 4] = 4'(rest % 10);
			rest = rest / 10;
		end
		return digits;
	endfunction

	function automatic logic nibbles_decimal(input freq_counter_pkg::bcd_t value);
		logic ok;
		ok = 1'b1;
		for (int i = 0; i < `FC_DIGITS; i++) begin
			if (value[4*i +: 4] > 4'd9) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	// lit segments g..a, inverted for the common anode
	function automatic freq_counter_pkg::seg_t decode_digit(input logic [3:0] digit);
		logic [6:0] lit;
		case (digit)
			4'd0: lit = 7'h3f;
			4'd1: lit = 7'h06;
			4'd2: lit = 7'h5b;
			4'd3: lit = 7'h4f;
			4'd4: lit = 7'h66;
			4'd5: lit = 7'h6d;
			4'd6: lit = 7'h7d;
			4'd7: lit = 7'h07;
			4'd8: lit = 7'h7f;
			4'd9: lit = 7'h6f;
			default: lit = 7'h00;
		endcase
		return ~lit;
	endfunction

	function automatic int onehot_index(input freq_counter_pkg::anode_t value);
		int index;
		index = 0;
		for (int i = `FC_DIGITS - 1; i >= 0; i--) begin
			if (value[i]) begin
				index = i;
			end
		end
		return index;
	endfunction

	// reference square wave
	initial begin : reference_wave
		ref_in = 1'b0;
		forever begin
			repeat (REF_HALF) @(posedge clock);
			ref_in <= ~ref_in;
		end
	end

	// measured wave, fast then slow
	initial begin : measured_wave
		int half;
		int elapsed;
		logic [31:0] pick;
		meas_in = 1'b0;
		elapsed = 0;
		forever begin
			if (elapsed < FAST_CLOCKS) begin
				pick = $unsigned($random(seed)) % 32'd2;
				half = 2 + int'(pick);
			end else begin
				pick = $unsigned($random(seed)) % 32'd41;
				half = 20 + int'(pick);
			end
			repeat (half) @(posedge clock);
			meas_in <= ~meas_in;
			elapsed = elapsed + half;
		end
	end

	// own synchronizers, gate phase length, tally queue and reading check
	always @(posedge clock) begin : reference_model
		logic ref_rise;
		logic meas_rise;
		int count;
		longint expected;
		if (reset) begin
			ref_pipe <= '0;
			meas_pipe <= '0;
			gate_seen <= 1'b0;
			ref_edges <= 0;
			meas_count <= 0;
		end else begin
			ref_rise = ref_pipe[`FC_SYNC_STAGES-1] & ~ref_pipe[`FC_SYNC_STAGES];
			meas_rise = meas_pipe[`FC_SYNC_STAGES-1] & ~meas_pipe[`FC_SYNC_STAGES];
			ref_pipe <= {ref_pipe[`FC_SYNC_STAGES-1:0], ref_in};
			meas_pipe <= {meas_pipe[`FC_SYNC_STAGES-1:0], meas_in};
			gate_seen <= gate;
			// gate moved on the previous edge
			if (gate != gate_seen) begin
				assert (ref_edges == GATE_EDGES)
				else report_mismatch("reference edges per gate phase", 64'(ref_edges),
					64'(GATE_EDGES));
				ref_edges <= ref_rise ? 1 : 0;
			end else if (ref_rise) begin
				ref_edges <= ref_edges + 1;
			end
			if (gate_seen && !gate) begin
				tally_queue.push_back(meas_count);
				meas_count <= 0;
			end else if (gate && meas_rise) begin
				meas_count <= meas_count + 1;
			end
			if (bcd_valid) begin
				assert (tally_queue.size() > 0)
				else report_failure("bcd_valid arrived with no closed gate behind it");
				count = tally_queue.pop_front();
				expected = (longint'(count) * longint'(REF_FREQ_100HZ)) >> GATE_LOG2;
				if (expected > READING_LIMIT) begin
					expected = READING_LIMIT;
				end
				assert (nibbles_decimal(bcd))
				else report_failure($sformatf("bcd 0x%h holds a nibble above 9", bcd));
				assert (bcd == to_bcd(expected))
				else report_mismatch("bcd", 64'(bcd), 64'(to_bcd(expected)));
				readings_taken <= readings_taken + 1;
				if (expected == READING_LIMIT) begin
					saturated_readings <= saturated_readings + 1;
				end else begin
					plain_readings <= plain_readings + 1;
				end
			end
		end
	end

	// scan order and segment decode of the held reading
	always @(posedge clock) begin : display_checks
		freq_counter_pkg::seg_t expected_segment;
		if (reset) begin
			shown_bcd <= '0;
			anode_seen <= freq_counter_pkg::anode_t'(1);
		end else begin
			expected_segment = decode_digit(shown_bcd[4*onehot_index(anode) +: 4]);
			assert (segment == expected_segment)
			else report_mismatch("segment", 64'(segment), 64'(expected_segment));
			if (anode != anode_seen) begin
				assert (anode == {anode_seen[`FC_DIGITS-2:0], anode_seen[`FC_DIGITS-1]})
				else report_mismatch("anode", 64'(anode),
					64'({anode_seen[`FC_DIGITS-2:0], anode_seen[`FC_DIGITS-1]}));
			end
			anode_seen <= anode;
			if (bcd_valid) begin
				shown_bcd <= bcd;
			end
		end
	end

	anode_one_hot: assert property (
		@(posedge clock) disable iff (reset)
		$onehot(anode)
	) else report_failure("anode is not one-hot");

	always @(posedge clock) begin : watchdog
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			report_failure("timeout, readings did not arrive in time");
		end
	end

	initial begin : main_sequence
		reset = 1'b1;
		repeat (4) @(posedge clock);
		reset <= 1'b0;
		// outputs still show their reset values here
		assert (gate == 1'b0)
		else report_mismatch("gate", 64'(gate), 64'(0));
		assert (bcd_valid == 1'b0)
		else report_mismatch("bcd_valid", 64'(bcd_valid), 64'(0));
		assert (anode == freq_counter_pkg::anode_t'(1))
		else report_mismatch("anode", 64'(anode), 64'(1));
		assert (segment == decode_digit(4'd0))
		else report_mismatch("segment", 64'(segment), 64'(decode_digit(4'd0)));
		wait (readings_taken >= READINGS_WANTED);
		@(posedge clock);
		assert (saturated_readings > 0)
		else report_failure("no saturated reading was reached");
		assert (plain_readings > 0)
		else report_failure("no reading below the display limit was reached");
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- freq_counter.f
+incdir+source
source/freq_counter_pkg.sv
source/gate_timer.sv
source/edge_tally.sv
source/rate_scaler.sv
source/bcd_converter.sv
source/digit_scanner.sv
source/freq_counter_top.sv
tb/freq_counter_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the frequency counter testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert --timescale 1ns/10ps --top-module freq_counter_tb \
	-f freq_counter.f -o freq_counter_sim > sim.log 2>&1 &&
	./obj_dir/freq_counter_sim >> sim.log 2>&1 ||
	echo "build or simulation ended with an error status" >> sim.log

cat sim.log
grep -q ">>> FAIL" sim.log && exit 1
grep -q ">>> PASS" sim.log
